// ==== testbench/tcb_sys_golden.txt ====
// columns: wen _ adr _ ben _ wdt _ expected rdt _ expected err
// rdt is compared on reads only, err on every transaction
// RAM full-word writes, then reads back to back
1_00000000_f_11223344_00000000_0
1_00000004_f_55667788_00000000_0
1_000003fc_f_a5a5a5a5_00000000_0
0_00000000_f_00000000_11223344_0
0_00000004_f_00000000_55667788_0
0_000003fc_f_00000000_a5a5a5a5_0
1_00000010_f_deadbeef_00000000_0
0_00000010_f_00000000_deadbeef_0
// RAM byte enables, lanes 0 and 2, then lanes 1 and 3
1_00000010_5_11223344_00000000_0
0_00000010_f_00000000_de22be44_0
1_00000004_a_aabbccdd_00000000_0
0_00000004_f_00000000_aa66cc88_0
// register block scratch and identifier
1_00001000_f_cafef00d_00000000_0
1_00001004_f_0badc0de_00000000_0
0_00001000_f_00000000_cafef00d_0
0_00001004_f_00000000_0badc0de_0
0_00001008_f_00000000_7cb50100_0
1_00001004_3_ffff1234_00000000_0
0_00001004_f_00000000_0bad1234_0
// identifier write and offset 3 both fail
1_00001008_f_12345678_00000000_1
0_00001008_f_00000000_7cb50100_0
0_0000100c_f_00000000_00000000_1
1_0000100c_f_87654321_00000000_1
// unmapped addresses
0_00002000_f_00000000_00000000_1
1_00002000_f_01020304_00000000_1
0_00000400_f_00000000_00000000_1
// alternating devices every cycle
0_00000000_f_00000000_11223344_0
0_00001000_f_00000000_cafef00d_0
0_00000004_f_00000000_aa66cc88_0
0_00001008_f_00000000_7cb50100_0
0_00002000_f_00000000_00000000_1
0_000003fc_f_00000000_a5a5a5a5_0

// ==== verilog.f ====
design/tcb_pkg.sv
design/tcb_if.sv
design/tcb_dec.sv
design/tcb_mem.sv
design/tcb_csr.sv
design/tcb_sys_top.sv
testbench/tcb_sys_chk.sv
testbench/tcb_sys_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the TCB subsystem testbench with Verilator, run it, check the log
cd "$(dirname "$0")" && rm -f sim.log || exit 1
{ verilator --binary --timing -f verilog.f --top-module tcb_sys_tb -o tcb_sys_sim \
  && ./obj_dir/tcb_sys_sim; } > sim.log 2>&1
cat sim.log
grep -q "Simulation PASSED" sim.log && echo "run_sim: pass" || { echo "run_sim: fail"; exit 1; }

// ==== testbench/tcb_sys_tb.sv ====
// TCB subsystem testbench
// clock, reset and a driver that replays the golden transactions
// on the top-level request port, one per ready cycle

`timescale 1ns/10ps

module tcb_sys_tb
  import tcb_pkg::*;
();

  // record layout: wen, adr, ben, wdt, rdt, err (108 bits)
  localparam int rec_max = 64;

  // DUT ports
  logic sub;
  logic rst_n;
  logic vld;
  logic wen;
  adr_t adr;
  ben_t ben;
  dat_t wdt;
  logic rdy;
  dat_t rdt;
  logic err;

  // checker results
  int chk_cnt;
  int rdt_errs;
  int err_errs;
  int other_errs;

  // golden records
  logic [107:0] recs [rec_max];
  int           n_rec;
  int           idx;
  int           cyc;

  ////////////////////////////////////////////////////////////////////////////
  // DUT and checker
  ////////////////////////////////////////////////////////////////////////////

  tcb_sys_top UUT (
    .sub   (sub),
    .rst_n (rst_n),
    .vld   (vld),
    .wen   (wen),
    .adr   (adr),
    .ben   (ben),
    .wdt   (wdt),
    .rdy   (rdy),
    .rdt   (rdt),
    .err   (err)
  );

  tcb_sys_chk u_chk (
    .sub        (sub),
    .rst_n      (rst_n),
    .vld        (vld),
    .rdy        (rdy),
    .rdt        (rdt),
    .err        (err),
    .chk_cnt    (chk_cnt),
    .rdt_errs   (rdt_errs),
    .err_errs   (err_errs),
    .other_errs (other_errs)
  );

  // 10 ns clock
  initial begin
    sub = 1'b0;
    forever #5 sub = ~sub;
  end

  // unused slots carry wen 0xf, which ends the count
  task automatic load_records();
    for (int i = 0; i < rec_max; i++) begin
      recs[i] = {4'hf, 104'(i)};
    end
    $readmemh("testbench/tcb_sys_golden.txt", recs);
    n_rec = 0;
    while (n_rec < rec_max && recs[n_rec][107:104] != 4'hf) begin
      n_rec++;
    end
  endtask

  // one request onto the bus
  task automatic drive_record(input int i);
    vld <= 1'b1;
    wen <= recs[i][104];
    adr <= recs[i][103:72];
    ben <= recs[i][71:68];
    wdt <= recs[i][67:36];
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst_n = 1'b0;
    vld   = 1'b0;
    wen   = 1'b0;
    adr   = '0;
    ben   = '0;
    wdt   = '0;
    load_records();
    // reset for 5 cycles
    repeat (5) @(posedge sub);
    rst_n <= 1'b1;
    @(posedge sub);
    idx = 0;
    if (n_rec > 0) begin
      drive_record(0);
    end
    // vld stays high, a ready cycle completes the transfer
    while (idx < n_rec) begin
      @(posedge sub);
      if (rdy) begin
        idx++;
        if (idx < n_rec) begin
          drive_record(idx);
        end else begin
          vld <= 1'b0;
        end
      end
    end
    // last response, then a little idle time
    while (chk_cnt < n_rec) begin
      @(posedge sub);
    end
    repeat (2) @(posedge sub);
    $display("checked %0d of %0d transactions, errors: rdt %0d, err %0d, other %0d",
             chk_cnt, n_rec, rdt_errs, err_errs, other_errs);
    if (chk_cnt == n_rec && rdt_errs + err_errs + other_errs == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // cycle limit, four cycles per record plus reset slack
  initial begin
    cyc = 0;
    while (cyc < 4 * n_rec + 20) begin
      @(posedge sub);
      cyc++;
    end
    $display("timeout: the run did not finish within %0d cycles", cyc);
    $display("Simulation FAILED");
    $finish;
  end

endmodule : tcb_sys_tb

// ==== testbench/tcb_sys_chk.sv ====
// TCB subsystem checker
// follows every transfer on the top-level port and compares
// the response one cycle later with the golden record

`timescale 1ns/10ps

module tcb_sys_chk
  import tcb_pkg::*;
(
  input  logic sub,
  input  logic rst_n,
  input  logic vld,
  input  logic rdy,
  input  dat_t rdt,
  input  logic err,
  output int   chk_cnt,
  output int   rdt_errs,
  output int   err_errs,
  output int   other_errs
);

  localparam int rec_max = 64;

  logic [107:0] recs [rec_max];
  int           n_rec;
  // next record to expect, and the one awaiting its response
  int           nxt;
  logic         pend;
  int           pend_idx;

  initial begin
    for (int i = 0; i < rec_max; i++) begin
      recs[i] = {4'hf, 104'(i)};
    end
    $readmemh("testbench/tcb_sys_golden.txt", recs);
    n_rec = 0;
    while (n_rec < rec_max && recs[n_rec][107:104] != 4'hf) begin
      n_rec++;
    end
  end

  // index, direction, target and address
  function automatic string txn_name(input int i);
    logic [31:0] a;
    string       tgt;
    a = recs[i][103:72];
    if (a < 32'h400) begin
      tgt = "ram";
    end else if (a[31:4] == 28'h100) begin
      tgt = "csr";
    end else begin
      tgt = "unmapped";
    end
    return $sformatf("txn%0d_%s_%s_%h", i, recs[i][104] ? "wr" : "rd", tgt, a);
  endfunction

  // err always, rdt on reads only
  task automatic check_response(input int i);
    logic [107:0] r;
    r = recs[i];
    chk_cnt++;
    if (err !== r[0]) begin
      err_errs++;
      $display("error: %s err expected %0b actual %0b", txn_name(i), r[0], err);
    end
    if (!r[104] && rdt !== r[35:4]) begin
      rdt_errs++;
      $display("error: %s rdt expected %h actual %h", txn_name(i), r[35:4], rdt);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // sampling at the falling edge, between driver updates
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge sub) begin
    if (!rst_n) begin
      chk_cnt    = 0;
      rdt_errs   = 0;
      err_errs   = 0;
      other_errs = 0;
      nxt        = 0;
      pend       = 1'b0;
      pend_idx   = 0;
    end else begin
      // response of the transfer at the last rising edge
      if (pend) begin
        check_response(pend_idx);
      end
      pend = 1'b0;
      // request that transfers at the coming rising edge
      if (vld) begin
        if (!rdy) begin
          other_errs++;
          $display("ready was low for a request, no device here inserts wait states");
        end else if (nxt >= n_rec) begin
          other_errs++;
          $display("a transfer was seen after the last golden record");
        end else begin
          pend     = 1'b1;
          pend_idx = nxt;
          nxt++;
        end
      end
    end
  end

endmodule : tcb_sys_chk

// ==== design/tcb_sys_top.sv ====
// TCB subsystem top level
// one upstream port decoded onto a RAM and a register block

`timescale 1ns/10ps

module tcb_sys_top
  import tcb_pkg::*;
#(
  parameter int unsigned PN = 2,
  // port 1: registers at 0x0000_100x, port 0: RAM at 0x000-0x3ff
  parameter logic [PN-1:0][tcb_aw-1:0] AS = {
    32'b0000_0000_0000_0000_0001_0000_0000_xxxx,
    32'b0000_0000_0000_0000_0000_00xx_xxxx_xxxx
  },
  parameter int unsigned MEM_AW = 8
)(
  input  logic sub,
  input  logic rst_n,
  // request
  input  logic vld,
  input  logic wen,
  input  adr_t adr,
  input  ben_t ben,
  input  dat_t wdt,
  output logic rdy,
  // response
  output dat_t rdt,
  output logic err
);

  // upstream bus and one bus per device
  tcb_if bus_up (.sub(sub), .rst_n(rst_n));
  tcb_if bus_dn [PN-1:0] (.sub(sub), .rst_n(rst_n));

  // plain ports onto the upstream bus
  assign bus_up.vld = vld;
  assign bus_up.wen = wen;
  assign bus_up.adr = adr;
  assign bus_up.ben = ben;
  assign bus_up.wdt = wdt;
  assign rdy = bus_up.rdy;
  assign rdt = bus_up.rdt;
  assign err = bus_up.err;

  ////////////////////////////////////////////////////////////////////////////
  // decoder and devices
  ////////////////////////////////////////////////////////////////////////////

  tcb_dec #(
    .PN (PN),
    .AS (AS)
  ) u_dec (
    .host (bus_up),
    .dev  (bus_dn)
  );

  // port 0
  tcb_mem #(
    .MEM_AW (MEM_AW)
  ) u_mem (
    .bus (bus_dn[0])
  );

  // port 1
  tcb_csr u_csr (
    .bus (bus_dn[1])
  );

endmodule : tcb_sys_top

// ==== design/tcb_csr.sv ====
// TCB control/status register block
// two byte-enabled scratch registers and a read-only identifier,
// bad accesses are flagged on err

`timescale 1ns/10ps

module tcb_csr
  import tcb_pkg::*;
(
  tcb_if.dev bus
);

  // scratch0 at index 0, scratch1 at index 1
  dat_t     scratch [2];

  logic     trn;
  csr_ofs_t ofs;
  dat_t     rd_data;
  logic     acc_err;

  assign trn = bus.vld & bus.rdy;
  assign ofs = bus.adr[3:2];

  ////////////////////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    rd_data = '0;
    acc_err = 1'b0;
    case (ofs)
      csr_ofs_scratch0: rd_data = scratch[0];
      csr_ofs_scratch1: rd_data = scratch[1];
      csr_ofs_id: begin
        rd_data = csr_id_value;
        // identifier is read only
        acc_err = bus.wen;
      end
      // offset 3, nothing there
      default: acc_err = 1'b1;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // scratch registers
  ////////////////////////////////////////////////////////////////////////////

  for (genvar r = 0; r < 2; r++) begin : g_scratch
    always_ff @(posedge bus.sub or negedge bus.rst_n) begin
      if (!bus.rst_n) begin
        scratch[r] <= '0;
      end else if (trn && bus.wen && (ofs == csr_ofs_t'(r))) begin
        for (int b = 0; b < tcb_bw; b++) begin
          if (bus.ben[b]) begin
            scratch[r][8*b +: 8] <= bus.wdt[8*b +: 8];
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // response
  ////////////////////////////////////////////////////////////////////////////

  // data for good reads only, zero on writes and errors
  always_ff @(posedge bus.sub or negedge bus.rst_n) begin
    if (!bus.rst_n) begin
      bus.rdt <= '0;
      bus.err <= 1'b0;
    end else begin
      // err pulses for one cycle per failed transfer
      bus.err <= trn & acc_err;
      if (trn) begin
        bus.rdt <= (bus.wen || acc_err) ? '0 : rd_data;
      end
    end
  end

  // always ready
  assign bus.rdy = 1'b1;

endmodule : tcb_csr

// ==== design/tcb_mem.sv ====
// TCB RAM device
// single-port word memory with byte lane write enables,
// read data one cycle after the transfer

`timescale 1ns/10ps

module tcb_mem
  import tcb_pkg::*;
#(
  // word address width, 2**MEM_AW words
  parameter int unsigned MEM_AW = 8
)(
  tcb_if.dev bus
);

  // storage
  dat_t mem [2**MEM_AW];

  logic              trn;
  logic [MEM_AW-1:0] wrd_adr;

  assign trn = bus.vld & bus.rdy;

  // byte address to word index
  assign wrd_adr = bus.adr[MEM_AW+1:2];

  ////////////////////////////////////////////////////////////////////////////
  // write
  ////////////////////////////////////////////////////////////////////////////

  // only enabled lanes change
  always_ff @(posedge bus.sub) begin
    if (trn && bus.wen) begin
      for (int b = 0; b < tcb_bw; b++) begin
        if (bus.ben[b]) begin
          mem[wrd_adr][8*b +: 8] <= bus.wdt[8*b +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read
  ////////////////////////////////////////////////////////////////////////////

  // rdt holds its value between reads
  always_ff @(posedge bus.sub or negedge bus.rst_n) begin
    if (!bus.rst_n) begin
      bus.rdt <= '0;
    end else if (trn && !bus.wen) begin
      bus.rdt <= mem[wrd_adr];
    end
  end

  // never stalls, never fails
  assign bus.rdy = 1'b1;
  assign bus.err = 1'b0;

endmodule : tcb_mem

// ==== design/tcb_dec.sv ====
// TCB address decoder
// routes one upstream port to PN device ports by wildcard address match,
// muxes the response back and answers unmapped addresses with an error

`timescale 1ns/10ps

module tcb_dec
  import tcb_pkg::*;
#(
  parameter int unsigned PN = 2,
  // one wildcard pattern per device port
  parameter logic [PN-1:0][tcb_aw-1:0] AS = '0
)(
  tcb_if.dev host,
  tcb_if.mgr dev [PN-1:0]
);

  // select width, at least one bit
  localparam int unsigned SW = (PN > 1) ? $clog2(PN) : 1;

  // lowest matching port wins
  function automatic logic [SW-1:0] prio_enc(input logic [PN-1:0] hit);
    logic [SW-1:0] sel;
    sel = '0;
    for (int i = PN - 1; i >= 0; i--) begin
      if (hit[i]) begin
        sel = i[SW-1:0];
      end
    end
    return sel;
  endfunction

  // request side decode
  logic [PN-1:0] dec_hit;
  logic [SW-1:0] req_sel;
  logic          req_miss;
  logic          host_trn;

  // response side select, one cycle behind
  logic [SW-1:0] rsp_sel;
  logic          rsp_miss;

  // device responses gathered for indexing
  dat_t dev_rdt [PN];
  logic dev_err [PN];
  logic dev_rdy [PN];

  ////////////////////////////////////////////////////////////////////////////
  // address decode
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < PN; i++) begin : g_dec
    assign dec_hit[i] = host.adr ==? AS[i];
  end

  assign req_sel  = prio_enc(dec_hit);
  assign req_miss = ~|dec_hit;
  assign host_trn = host.vld & host.rdy;

  // select follows each transfer into its response cycle
  always_ff @(posedge host.sub or negedge host.rst_n) begin
    if (!host.rst_n) begin
      rsp_sel <= '0;
    end else if (host_trn) begin
      rsp_sel <= req_sel;
    end
  end

  // error responder flag, high only in the cycle after an unmapped transfer
  always_ff @(posedge host.sub or negedge host.rst_n) begin
    if (!host.rst_n) begin
      rsp_miss <= 1'b0;
    end else begin
      rsp_miss <= host_trn & req_miss;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // request fan-out and response gather
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < PN; i++) begin : g_port
    // valid only toward the selected port
    assign dev[i].vld = host.vld & ~req_miss & (req_sel == SW'(i));
    // payload goes everywhere
    assign dev[i].wen = host.wen;
    assign dev[i].adr = host.adr;
    assign dev[i].ben = host.ben;
    assign dev[i].wdt = host.wdt;
    // interface array can't take a variable index
    assign dev_rdt[i] = dev[i].rdt;
    assign dev_err[i] = dev[i].err;
    assign dev_rdy[i] = dev[i].rdy;
  end

  ////////////////////////////////////////////////////////////////////////////
  // response mux
  ////////////////////////////////////////////////////////////////////////////

  // unmapped requests are always accepted here
  assign host.rdy = req_miss ? 1'b1 : dev_rdy[req_sel];

  // response phase uses the registered select
  assign host.rdt = rsp_miss ? '0 : dev_rdt[rsp_sel];
  assign host.err = rsp_miss | dev_err[rsp_sel];

endmodule : tcb_dec

// ==== design/tcb_if.sv ====
// TCB interface
// request fields from the manager, ready plus the delayed response
// from the device, one-cycle read latency

`timescale 1ns/10ps

interface tcb_if
  import tcb_pkg::*;
(
  input logic sub,
  input logic rst_n
);

  // request phase
  logic vld;
  logic wen;
  adr_t adr;
  ben_t ben;
  dat_t wdt;
  // backpressure, also request phase
  logic rdy;

  // response phase, one cycle after the transfer
  dat_t rdt;
  logic err;

  // manager side drives the request
  modport mgr (
    input  sub,
    input  rst_n,
    output vld,
    output wen,
    output adr,
    output ben,
    output wdt,
    input  rdy,
    input  rdt,
    input  err
  );

  // device side answers
  modport dev (
    input  sub,
    input  rst_n,
    input  vld,
    input  wen,
    input  adr,
    input  ben,
    input  wdt,
    output rdy,
    output rdt,
    output err
  );

endinterface : tcb_if

// ==== design/tcb_pkg.sv ====
// TCB subsystem shared definitions
// bus widths, vector types and the register block map

package tcb_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // bus widths
  ////////////////////////////////////////////////////////////////////////////

  // byte address
  localparam int unsigned tcb_aw = 32;
  // data word
  localparam int unsigned tcb_dw = 32;
  // one enable per byte lane
  localparam int unsigned tcb_bw = tcb_dw / 8;

  ////////////////////////////////////////////////////////////////////////////
  // vector types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [tcb_aw-1:0] adr_t;
  typedef logic [tcb_dw-1:0] dat_t;
  typedef logic [tcb_bw-1:0] ben_t;

  ////////////////////////////////////////////////////////////////////////////
  // register block map
  ////////////////////////////////////////////////////////////////////////////

  // word offset inside the register block, taken from adr[3:2]
  typedef logic [1:0] csr_ofs_t;

  // value seen when reading the identifier
  localparam dat_t csr_id_value = 32'h7cb5_0100;

  // word offsets
  localparam csr_ofs_t csr_ofs_scratch0 = 2'd0;
  localparam csr_ofs_t csr_ofs_scratch1 = 2'd1;
  localparam csr_ofs_t csr_ofs_id       = 2'd2;
  // offset 3 has no register behind it

endpackage : tcb_pkg
